//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pixel_shader_tb -f files.f
	@out="$$(./obj_dir/Vpixel_shader_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

//--- design/cross_product.sv
`timescale 1ns/1ps

module cross_product (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   valid_in,
    input  shader_pkg::edge_pair_t edges,
    output logic                   valid_out,
    output shader_pkg::normal_t    normal
);

    // partial products of e1 x e2, named by the component pair
    typedef struct packed {
        logic signed [shader_pkg::NORM_W-1:0] yz;
        logic signed [shader_pkg::NORM_W-1:0] zy;
        logic signed [shader_pkg::NORM_W-1:0] zx;
        logic signed [shader_pkg::NORM_W-1:0] xz;
        logic signed [shader_pkg::NORM_W-1:0] xy;
        logic signed [shader_pkg::NORM_W-1:0] yx;
    } products_t;

    products_t prod_q;
    logic      prod_valid_q;

    function automatic logic signed [shader_pkg::NORM_W-1:0] widen(
        input logic signed [shader_pkg::EDGE_W-1:0] v
    );
        return {{(shader_pkg::NORM_W - shader_pkg::EDGE_W){v[shader_pkg::EDGE_W-1]}}, v};
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            prod_valid_q <= 1'b0;
            valid_out    <= 1'b0;
        end else begin
            prod_valid_q <= valid_in;
            valid_out    <= prod_valid_q;
        end
    end

    // stage one, six multiplies
    always_ff @(posedge clk_in) begin
        prod_q.yz <= widen(edges.e1.y) * widen(edges.e2.z);
        prod_q.zy <= widen(edges.e1.z) * widen(edges.e2.y);
        prod_q.zx <= widen(edges.e1.z) * widen(edges.e2.x);
        prod_q.xz <= widen(edges.e1.x) * widen(edges.e2.z);
        prod_q.xy <= widen(edges.e1.x) * widen(edges.e2.y);
        prod_q.yx <= widen(edges.e1.y) * widen(edges.e2.x);
    end

    // stage two, differences give the normal
    always_ff @(posedge clk_in) begin
        normal.nx <= prod_q.yz - prod_q.zy;
        normal.ny <= prod_q.zx - prod_q.xz;
        normal.nz <= prod_q.xy - prod_q.yx;
    end

endmodule

//--- design/edge_vectors.sv
`timescale 1ns/1ps

module edge_vectors (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   valid_in,
    input  shader_pkg::triangle_t  triangle,
    output logic                   valid_out,
    output shader_pkg::edge_pair_t edges
);

    // sign-extend both coordinates by one bit so the difference cannot overflow
    function automatic logic signed [shader_pkg::EDGE_W-1:0] sub_ext(
        input logic signed [shader_pkg::COORD_W-1:0] a,
        input logic signed [shader_pkg::COORD_W-1:0] b
    );
        return {a[shader_pkg::COORD_W-1], a} - {b[shader_pkg::COORD_W-1], b};
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk_in) begin
        edges.e1.x <= sub_ext(triangle.v1.x, triangle.v0.x);
        edges.e1.y <= sub_ext(triangle.v1.y, triangle.v0.y);
        edges.e1.z <= sub_ext(triangle.v1.z, triangle.v0.z);
        edges.e2.x <= sub_ext(triangle.v2.x, triangle.v0.x);
        edges.e2.y <= sub_ext(triangle.v2.y, triangle.v0.y);
        edges.e2.z <= sub_ext(triangle.v2.z, triangle.v0.z);
    end

endmodule

//--- design/index_divider.sv
`timescale 1ns/1ps

module index_divider (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          valid_in,
    input  shader_pkg::energy_t           energy,
    output logic                          valid_out,
    output logic [shader_pkg::INDEX_W-1:0] index,
    output logic                          away
);

    // one item in flight through the divider
    typedef struct packed {
        logic [shader_pkg::ENERGY_W-1:0] rem;
        logic [shader_pkg::MAG_W-1:0]    div;
        logic [shader_pkg::INDEX_W-1:0]  quot;
        logic                            away;
    } div_state_t;

    // stage s decides quotient bit INDEX_W-1-s, msb first
    for (genvar s = 0; s < shader_pkg::INDEX_W; s++) begin : g_stage
        div_state_t                   cur;
        div_state_t                   nxt;
        logic                         cur_valid;
        logic [shader_pkg::DIV_W-1:0] rem_ext;
        logic [shader_pkg::DIV_W-1:0] div_shifted;
        logic [shader_pkg::DIV_W-1:0] diff;
        logic                         fits;
        div_state_t                   state_q;
        logic                         valid_q;

        if (s == 0) begin : g_head
            assign cur = '{rem: energy.num, div: energy.mag, quot: '0, away: energy.away};
            assign cur_valid = valid_in;
        end else begin : g_tail
            assign cur       = g_stage[s-1].state_q;
            assign cur_valid = g_stage[s-1].valid_q;
        end

        assign rem_ext     = {{(shader_pkg::DIV_W - shader_pkg::ENERGY_W){1'b0}}, cur.rem};
        assign div_shifted = {{(shader_pkg::DIV_W - shader_pkg::MAG_W){1'b0}}, cur.div}
                             << (shader_pkg::INDEX_W - 1 - s);
        assign diff        = rem_ext - div_shifted;

        // a zero divisor never fits, so a degenerate normal ends at quotient 0
        assign fits = (cur.div != '0) && (rem_ext >= div_shifted);

        always_comb begin
            nxt = cur;
            if (fits) begin
                nxt.rem = diff[shader_pkg::ENERGY_W-1:0];
                nxt.quot[shader_pkg::INDEX_W-1-s] = 1'b1;
            end
        end

        always_ff @(posedge clk_in) begin
            if (rst_in) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= cur_valid;
            end
        end

        always_ff @(posedge clk_in) begin
            state_q <= nxt;
        end
    end

    assign valid_out = g_stage[shader_pkg::INDEX_W-1].valid_q;
    assign index     = g_stage[shader_pkg::INDEX_W-1].state_q.quot;
    assign away      = g_stage[shader_pkg::INDEX_W-1].state_q.away;

endmodule

//--- design/normal_energy.sv
`timescale 1ns/1ps

module normal_energy (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                valid_in,
    input  shader_pkg::normal_t normal,
    output logic                valid_out,
    output shader_pkg::energy_t energy
);

    logic signed [shader_pkg::MAG_W-1:0] nx_w;
    logic signed [shader_pkg::MAG_W-1:0] ny_w;
    logic signed [shader_pkg::MAG_W-1:0] nz_w;
    logic        [shader_pkg::MAG_W-1:0] sq_x;
    logic        [shader_pkg::MAG_W-1:0] sq_y;
    logic        [shader_pkg::MAG_W-1:0] sq_z;

    // widen first so the squares are formed at full width
    assign nx_w = {{(shader_pkg::MAG_W - shader_pkg::NORM_W){normal.nx[shader_pkg::NORM_W-1]}},
                   normal.nx};
    assign ny_w = {{(shader_pkg::MAG_W - shader_pkg::NORM_W){normal.ny[shader_pkg::NORM_W-1]}},
                   normal.ny};
    assign nz_w = {{(shader_pkg::MAG_W - shader_pkg::NORM_W){normal.nz[shader_pkg::NORM_W-1]}},
                   normal.nz};

    assign sq_x = nx_w * nx_w;
    assign sq_y = ny_w * ny_w;
    assign sq_z = nz_w * nz_w;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // num is 16*nz^2, never more than 16 times mag
    always_ff @(posedge clk_in) begin
        energy.mag  <= sq_x + sq_y + sq_z;
        energy.num  <= {sq_z[shader_pkg::ENERGY_W-5:0], 4'b0000};
        energy.away <= normal.nz[shader_pkg::NORM_W-1];
    end

endmodule

//--- design/pixel_shader.sv
`timescale 1ns/1ps

module pixel_shader (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  valid_in,
    input  shader_pkg::triangle_t triangle,
    output logic                  valid_out,
    output logic [7:0]            color_out
);

    logic                           edges_valid;
    shader_pkg::edge_pair_t         edges;
    logic                           normal_valid;
    shader_pkg::normal_t            normal;
    logic                           energy_valid;
    shader_pkg::energy_t            energy;
    logic                           index_valid;
    logic [shader_pkg::INDEX_W-1:0] index;
    logic                           away;

    // 1 cycle
    edge_vectors edge_vectors_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .triangle  (triangle),
        .valid_out (edges_valid),
        .edges     (edges)
    );

    // 2 cycles
    cross_product cross_product_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (edges_valid),
        .edges     (edges),
        .valid_out (normal_valid),
        .normal    (normal)
    );

    // 1 cycle
    normal_energy normal_energy_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (normal_valid),
        .normal    (normal),
        .valid_out (energy_valid),
        .energy    (energy)
    );

    // 5 cycles, one quotient bit each
    index_divider index_divider_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (energy_valid),
        .energy    (energy),
        .valid_out (index_valid),
        .index     (index),
        .away      (away)
    );

    // 1 cycle
    shade_output shade_output_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (index_valid),
        .index     (index),
        .away      (away),
        .valid_out (valid_out),
        .color_out (color_out)
    );

endmodule

//--- design/shade_output.sv
`timescale 1ns/1ps

module shade_output (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           valid_in,
    input  logic [shader_pkg::INDEX_W-1:0] index,
    input  logic                           away,
    output logic                           valid_out,
    output logic [7:0]                     color_out
);

    logic [7:0] shade;

    // faces turned from the viewer take the fixed back-face colour
    always_comb begin
        if (away) begin
            shade = shader_pkg::BACKFACE_COLOR;
        end else begin
            shade = shader_pkg::SHADE_TABLE[index];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            color_out <= 8'h00;
        end else begin
            valid_out <= valid_in;
            // hold the last colour between results
            if (valid_in) begin
                color_out <= shade;
            end
        end
    end

endmodule

//--- design/shader_pkg.sv
package shader_pkg;

    // coordinate and datapath widths
    localparam int COORD_W  = 12;
    localparam int EDGE_W   = COORD_W + 1;
    localparam int NORM_W   = 27;
    localparam int MAG_W    = 56;
    localparam int ENERGY_W = MAG_W + 2;
    localparam int INDEX_W  = 5;

    // comparison width inside the divider, divisor shifted by up to four places
    localparam int DIV_W = MAG_W + INDEX_W - 1;

    localparam int SHADE_LEVELS = 17;
    localparam int PIPE_LATENCY = 10;

    localparam logic [7:0] BACKFACE_COLOR = 8'hFF;

    // entry i is 16*i, the last one capped at 255
    localparam logic [7:0] SHADE_TABLE [SHADE_LEVELS] = '{
        8'h00, 8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60, 8'h70, 8'h80,
        8'h90, 8'hA0, 8'hB0, 8'hC0, 8'hD0, 8'hE0, 8'hF0, 8'hFF
    };

    typedef struct packed {
        logic signed [COORD_W-1:0] x;
        logic signed [COORD_W-1:0] y;
        logic signed [COORD_W-1:0] z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic signed [EDGE_W-1:0] x;
        logic signed [EDGE_W-1:0] y;
        logic signed [EDGE_W-1:0] z;
    } edge_t;

    typedef struct packed {
        edge_t e1;
        edge_t e2;
    } edge_pair_t;

    typedef struct packed {
        logic signed [NORM_W-1:0] nx;
        logic signed [NORM_W-1:0] ny;
        logic signed [NORM_W-1:0] nz;
    } normal_t;

    typedef struct packed {
        logic [MAG_W-1:0]    mag;
        logic [ENERGY_W-1:0] num;
        logic                away;
    } energy_t;

endpackage

//--- files.f
design/shader_pkg.sv
design/edge_vectors.sv
design/cross_product.sv
design/normal_energy.sv
design/index_divider.sv
design/shade_output.sv
design/pixel_shader.sv
sim/pixel_shader_props.sv
sim/pixel_shader_tb.sv

//--- sim/pixel_shader_props.sv
`timescale 1ns/1ps

module pixel_shader_props (
    input logic       clk_in,
    input logic       rst_in,
    input logic       valid_in,
    input logic       valid_out,
    input logic [7:0] color_out
);

    // nothing leaves the pipeline while it is held in reset
    a_reset_quiet: assert property (@(posedge clk_in) rst_in |=> !valid_out)
        else $error("valid_out high during reset");

    a_reset_release: assert property (@(posedge clk_in) $fell(rst_in) |=> !valid_out)
        else $error("valid_out high on the first cycle after reset");

    // fixed latency with no stalls
    a_latency: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_in |-> ##(shader_pkg::PIPE_LATENCY) valid_out
    ) else $error("result missing PIPE_LATENCY cycles after valid_in");

    // every result has a matching input
    a_no_orphan: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |-> $past(valid_in, shader_pkg::PIPE_LATENCY)
    ) else $error("valid_out without valid_in PIPE_LATENCY cycles earlier");

    a_color_known: assert property (
        @(posedge clk_in) disable iff (rst_in)
        valid_out |-> !$isunknown(color_out)
    ) else $error("color_out unknown while valid_out is high");

endmodule

bind pixel_shader pixel_shader_props props_i (.*);

//--- sim/pixel_shader_tb.sv
`timescale 1ns/1ps

module pixel_shader_tb;

    localparam int TOTAL_TRIS     = 223;
    localparam int TIMEOUT_CYCLES = 16 + TOTAL_TRIS * 4 + shader_pkg::PIPE_LATENCY + 100;

    // rows hold v0, v1, v2 as x y z; flat, swapped, 20 tilted, degenerate
    localparam int HAND [23][9] = '{
        '{0, 0, 0, 10, 0, 0, 0, 10, 0},
        '{0, 0, 0, 0, 10, 0, 10, 0, 0},
        '{0, 0, 0, 10, 0, 5, 0, 10, 0},
        '{0, 0, 0, 10, 0, 10, 0, 10, 0},
        '{0, 0, 0, 10, 0, 10, 0, 10, 10},
        '{0, 0, 0, 10, 0, 20, 0, 10, 0},
        '{0, 0, 0, 10, 0, 30, 0, 10, 0},
        '{5, 5, 5, 15, 5, 8, 5, 15, 9},
        '{-20, 30, 0, -10, 30, 7, -20, 40, 0},
        '{0, 0, 0, 10, 0, 5, 0, 10, 5},
        '{100, 100, 100, 110, 100, 100, 100, 110, 115},
        '{0, 0, 0, 10, 0, 2, 0, 10, 0},
        '{0, 0, 0, 10, 0, 4, 0, 10, 0},
        '{0, 0, 0, 10, 0, 6, 0, 10, 0},
        '{0, 0, 0, 10, 0, 8, 0, 10, 0},
        '{-50, -50, -50, -40, -50, -38, -50, -40, -50},
        '{0, 0, 0, 10, 0, -14, 0, 10, 0},
        '{0, 0, 0, 10, 0, 17, 0, 10, 3},
        '{0, 0, 0, 10, 0, 24, 0, 10, 0},
        '{100, -200, 50, 400, -200, 250, 100, 100, -100},
        '{-1000, 500, 0, -200, 500, 600, -1000, 1300, -400},
        '{0, 0, 0, 7, 3, 2, -2, 9, 4},
        '{0, 0, 0, 5, 5, 5, 10, 10, 10}
    };

    logic                  clk_in;
    logic                  rst_in;
    logic                  valid_in;
    shader_pkg::triangle_t triangle;
    logic                  valid_out;
    logic [7:0]            color_out;

    logic [7:0]  exp_q[$];
    logic [7:0]  exp_head = 8'h00;
    bit          exp_empty = 1'b1;
    logic [31:0] lcg_state = 32'd21;
    int          results_seen = 0;
    int          err_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          errs_before;
    logic [31:0] r;

    pixel_shader dut_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .triangle  (triangle),
        .valid_out (valid_out),
        .color_out (color_out)
    );

    always #5 clk_in = ~clk_in;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [shader_pkg::COORD_W-1:0] to_coord(input int v);
        return v[shader_pkg::COORD_W-1:0];
    endfunction

    function automatic shader_pkg::triangle_t hand_triangle(input int row);
        shader_pkg::triangle_t t;
        t.v0.x = to_coord(HAND[row][0]);
        t.v0.y = to_coord(HAND[row][1]);
        t.v0.z = to_coord(HAND[row][2]);
        t.v1.x = to_coord(HAND[row][3]);
        t.v1.y = to_coord(HAND[row][4]);
        t.v1.z = to_coord(HAND[row][5]);
        t.v2.x = to_coord(HAND[row][6]);
        t.v2.y = to_coord(HAND[row][7]);
        t.v2.z = to_coord(HAND[row][8]);
        return t;
    endfunction

    function automatic shader_pkg::triangle_t random_triangle();
        shader_pkg::triangle_t t;
        logic [31:0]           v;
        for (int k = 0; k < 9; k++) begin
            v = next_random();
            t[k*shader_pkg::COORD_W +: shader_pkg::COORD_W] = v[27:16];
        end
        return t;
    endfunction

    // cos^2 of the normal against (0,0,-1), floor(16*nz^2/mag), then 16*i capped
    function automatic logic [7:0] expected_color(input shader_pkg::triangle_t t);
        longint e1x, e1y, e1z, e2x, e2y, e2z;
        longint nx, ny, nz, mag, idx, shade;
        e1x = longint'(t.v1.x) - longint'(t.v0.x);
        e1y = longint'(t.v1.y) - longint'(t.v0.y);
        e1z = longint'(t.v1.z) - longint'(t.v0.z);
        e2x = longint'(t.v2.x) - longint'(t.v0.x);
        e2y = longint'(t.v2.y) - longint'(t.v0.y);
        e2z = longint'(t.v2.z) - longint'(t.v0.z);
        nx = e1y * e2z - e1z * e2y;
        ny = e1z * e2x - e1x * e2z;
        nz = e1x * e2y - e1y * e2x;
        mag = nx * nx + ny * ny + nz * nz;
        if (nz < 0) begin
            return 8'hFF;
        end
        idx = (mag == 0) ? 0 : (16 * nz * nz) / mag;
        shade = (idx * 16 > 255) ? 255 : idx * 16;
        return shade[7:0];
    endfunction

    task automatic drive_triangle(input shader_pkg::triangle_t t);
        @(negedge clk_in);
        triangle = t;
        valid_in = 1'b1;
        exp_q.push_back(expected_color(t));
    endtask

    task automatic idle_cycle();
        @(negedge clk_in);
        valid_in = 1'b0;
    endtask

    // wait until every outstanding result has been checked
    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk_in);
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (err_count == errs) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d check errors", name, err_count - errs);
        end
    endtask

    // retire the result shown last cycle, then expose the next expected colour
    always @(posedge clk_in) begin
        if (!rst_in && valid_out && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            results_seen++;
        end
        exp_empty = (exp_q.size() == 0);
        exp_head  = exp_empty ? 8'h00 : exp_q[0];
    end

    a_reset_zero: assert property (@(negedge clk_in) rst_in |-> (!valid_out && color_out == 8'h00))
        else begin
            $display("FAILED valid_out/color_out in reset expected 0/00 actual %h/%h",
                     valid_out, color_out);
            err_count++;
        end

    a_idle_zero: assert property (
        @(negedge clk_in) (!rst_in && !valid_out && results_seen == 0) |-> color_out == 8'h00
    ) else begin
        $display("FAILED color_out before first result expected 00 actual %h", color_out);
        err_count++;
    end

    a_color: assert property (
        @(negedge clk_in) disable iff (rst_in) (valid_out && !exp_empty) |-> color_out == exp_head
    ) else begin
        $display("FAILED color_out expected %h actual %h", exp_head, color_out);
        err_count++;
    end

    a_expected: assert property (@(negedge clk_in) disable iff (rst_in) valid_out |-> !exp_empty)
        else begin
            $display("a result came out with no triangle outstanding");
            err_count++;
        end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk_in   = 1'b0;
        rst_in   = 1'b1;
        valid_in = 1'b0;
        triangle = '0;
        errs_before = err_count;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        repeat (12) @(negedge clk_in);
        report_test("reset", errs_before);

        errs_before = err_count;
        drive_triangle(hand_triangle(0));
        drive_triangle(hand_triangle(1));
        drain();
        report_test("flat", errs_before);

        errs_before = err_count;
        for (int i = 2; i < 22; i++) begin
            drive_triangle(hand_triangle(i));
        end
        drain();
        report_test("tilted", errs_before);

        errs_before = err_count;
        drive_triangle(hand_triangle(22));
        drain();
        report_test("degenerate", errs_before);

        // back to back with an occasional idle cycle
        errs_before = err_count;
        for (int i = 0; i < 200; i++) begin
            r = next_random();
            if (r[2:0] == 3'd0) begin
                idle_cycle();
            end
            drive_triangle(random_triangle());
        end
        drain();
        report_test("streaming", errs_before);

        $display("tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
